//--- Makefile
# build and run the padding stage testbench with verilator
TOP = conv_pad_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- common/conv_pad_macros.svh
// sizes shared by every block of the same-padding stage
// included by the package and by modules that size ports or loops
`ifndef CONV_PAD_MACROS_SVH
`define CONV_PAD_MACROS_SVH

`define KW_MAX   7                           // largest odd kernel width
`define MEMBERS  24                          // lanes per beat
`define DATA_W   8                           // bits per lane
`define COLS_W   8                           // column counter width
`define CIN_W    6                           // channel counter width

`define BITS_KW  ($clog2(`KW_MAX + 1))       // edge code width
`define BITS_KW2 ($clog2(`KW_MAX / 2 + 1))   // half kernel width

`define APB_AW   4                           // apb address bits, four word registers
`define APB_DW   32                          // apb data bus

`endif

//--- common/conv_pad_pkg.sv
// types shared by the padding stage blocks and its testbench
// import with a wildcard in the module header
`include "conv_pad_macros.svh"

package conv_pad_pkg;

    typedef logic [`DATA_W-1:0]   lane_t;    // one lane value
    typedef lane_t [`MEMBERS-1:0] lanes_t;   // all lanes of a beat
    typedef logic [`MEMBERS-1:0]  mask_t;    // one bit per lane

    typedef logic [`BITS_KW2-1:0] kw2_t;     // kernel width / 2
    typedef logic [`BITS_KW-1:0]  clr_t;     // 0 centre, odd left, even right
    typedef logic [`COLS_W-1:0]   cols_t;
    typedef logic [`CIN_W-1:0]    cin_t;

    // flags riding with every beat
    typedef struct packed {
        logic is_config;                     // first beat of a frame, zero lanes
        logic is_cin_last;                   // last channel of a column
        logic is_cols_1_k2;                  // column == cols - 1 - kw2
        kw2_t kw2;                           // kernel of this frame
    } tag_t;

    typedef enum logic [1:0] {
        IDLE,                                // waiting for start
        CONFIG,                              // emitting the config beat
        STREAM                               // passing tagged data beats
    } tag_state_t;

endpackage

//--- common/conv_stream_if.sv
// one tagged beat between tagger, pad filter and lane masker
// en is the pipeline clock enable driven back from the output side
interface conv_stream_if
    import conv_pad_pkg::*;
();

    logic   valid;   // beat present this cycle
    tag_t   tag;     // flags of the beat
    lanes_t lanes;   // lane payload
    logic   en;      // stall control, beat moves when valid && en

    // tagger side
    modport source (
        output valid,
        output tag,
        output lanes,
        input  en
    );

    // filter and masker side, masker drives en
    modport sink (
        input  valid,
        input  tag,
        input  lanes,
        output en
    );

endinterface

//--- filelist.f
+incdir+common
common/conv_pad_pkg.sv
common/conv_stream_if.sv
hdl/apb_config.sv
hdl/user_tagger.sv
pad_filter/pad_filter.sv
hdl/lane_masker.sv
hdl/conv_pad_top.sv
tests/conv_pad_tb.sv

//--- hdl/apb_config.sv
// apb register block for kernel width, column count and channel count
// a write to 0xC pulses start for one cycle to launch a frame
`include "conv_pad_macros.svh"

module apb_config
    import conv_pad_pkg::*;
(
    input  logic               aclk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_AW-1:0] paddr,
    input  logic [`APB_DW-1:0] pwdata,
    output logic [`APB_DW-1:0] prdata,
    output logic               pready,
    output kw2_t               kw2,
    output cols_t              cols,
    output cin_t               cins,
    output logic               start
);

    logic wr;      // access phase of a write
    logic kw_ok;   // odd and within range

    assign pready = 1'b1;                                    // no wait states
    assign wr     = psel & penable & pwrite;
    assign kw_ok  = pwdata[0] && (pwdata <= `KW_MAX);

    always_ff @(posedge aclk) begin
        if (rst) begin
            kw2   <= '0;                                     // kw = 1
            cols  <= '0;
            cins  <= '0;
            start <= 1'b0;
        end else begin
            start <= wr && (paddr == 'hC);                   // single cycle pulse
            if (wr) begin
                case (paddr)
                    'h0: kw2  <= kw_ok ? kw2_t'(pwdata[`BITS_KW-1:1]) : '0;  // illegal -> kw 1
                    'h4: cols <= cols_t'(pwdata);
                    'h8: cins <= cin_t'(pwdata);
                    default: ;                               // 0xC handled above
                endcase
            end
        end
    end

    // read mux, valid in the access phase
    always_comb begin
        prdata = '0;
        case (paddr)
            'h0: prdata[`BITS_KW2:0] = {kw2, 1'b1};          // kw = 2 * kw2 + 1
            'h4: prdata[`COLS_W-1:0] = cols;
            'h8: prdata[`CIN_W-1:0]  = cins;
            default: prdata = '0;                            // start reads as zero
        endcase
    end

    a_penable_needs_psel: assert property (
        @(posedge aclk) disable iff (rst) penable |-> psel
    );

endmodule

//--- hdl/conv_pad_top.sv
// top of the horizontal padding stage, apb config plus tagged data path
// plain ports for the apb slave, the input stream and the output stream
`include "conv_pad_macros.svh"

module conv_pad_top
    import conv_pad_pkg::*;
(
    input  logic               aclk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_AW-1:0] paddr,
    input  logic [`APB_DW-1:0] pwdata,
    output logic [`APB_DW-1:0] prdata,
    output logic               pready,
    input  logic               in_valid,
    output logic               in_ready,
    input  lanes_t             in_lanes,
    output logic               out_valid,
    input  logic               out_ready,
    output lanes_t             out_lanes,
    output mask_t              out_keep,
    output clr_t               out_clr [`MEMBERS-1:0]
);

    kw2_t  kw2;
    cols_t cols;
    cin_t  cins;
    logic  start;
    mask_t keep_mask;
    logic  valid_mask;
    clr_t  clr [`MEMBERS-1:0];

    conv_stream_if beat_if ();                               // tagger -> filter, masker

    apb_config apb_config_i (
        .aclk    (aclk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .kw2     (kw2),
        .cols    (cols),
        .cins    (cins),
        .start   (start)
    );

    user_tagger user_tagger_i (
        .aclk     (aclk),
        .rst      (rst),
        .kw2      (kw2),
        .cols     (cols),
        .cins     (cins),
        .start    (start),
        .in_valid (in_valid),
        .in_lanes (in_lanes),
        .in_ready (in_ready),
        .beat     (beat_if.source)
    );

    pad_filter pad_filter_i (
        .aclk       (aclk),
        .rst        (rst),
        .beat       (beat_if.sink),
        .keep_mask  (keep_mask),
        .valid_mask (valid_mask),
        .clr        (clr)
    );

    lane_masker lane_masker_i (
        .aclk       (aclk),
        .rst        (rst),
        .keep_mask  (keep_mask),
        .valid_mask (valid_mask),
        .clr        (clr),
        .out_ready  (out_ready),
        .beat       (beat_if.sink),
        .out_valid  (out_valid),
        .out_lanes  (out_lanes),
        .out_keep   (out_keep),
        .out_clr    (out_clr)
    );

endmodule

//--- hdl/lane_masker.sv
// output side, zeroes dropped lanes and registers the beat with valid/ready
// also produces the pipeline enable for every upstream register
`include "conv_pad_macros.svh"

module lane_masker
    import conv_pad_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,
    input  mask_t       keep_mask,
    input  logic        valid_mask,
    input  clr_t        clr [`MEMBERS-1:0],
    input  logic        out_ready,
    conv_stream_if.sink beat,
    output logic        out_valid,
    output lanes_t      out_lanes,
    output mask_t       out_keep,
    output clr_t        out_clr [`MEMBERS-1:0]
);

    logic   take;        // beat lands in the output register
    lanes_t masked;

    assign beat.en = !out_valid | out_ready;                 // empty or draining
    assign take    = beat.en & beat.valid & valid_mask & !beat.tag.is_config;

    always_comb begin
        for (int m = 0; m < `MEMBERS; m++) begin
            masked[m] = keep_mask[m] ? beat.lanes[m] : '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (beat.en) begin
            out_valid <= take;                               // bubble when nothing taken
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            out_lanes <= masked;
            out_keep  <= keep_mask;
            for (int m = 0; m < `MEMBERS; m++) begin
                out_clr[m] <= keep_mask[m] ? clr[m] : '0;    // codes only on kept lanes
            end
        end
    end

    a_hold_on_stall: assert property (
        @(posedge aclk) disable iff (rst) (out_valid && !out_ready) |=> $stable(out_lanes)
    );

endmodule

//--- hdl/user_tagger.sv
// input side, emits a config beat per frame then tags each data beat
// channels are counted inside columns, frame ends after cols * cins beats
module user_tagger
    import conv_pad_pkg::*;
(
    input  logic         aclk,
    input  logic         rst,
    input  kw2_t         kw2,
    input  cols_t        cols,
    input  cin_t         cins,
    input  logic         start,
    input  logic         in_valid,
    input  lanes_t       in_lanes,
    output logic         in_ready,
    conv_stream_if.source beat
);

    tag_state_t state;
    kw2_t       kw2_q;        // frame kernel, frozen at start
    cols_t      cols_q;
    cin_t       cins_q;
    cols_t      col_cnt;
    cin_t       cin_cnt;
    cols_t      k2_col;       // cols - 1 - kw2
    cols_t      last_col;
    cin_t       last_cin;
    logic       cin_last;
    logic       col_last;
    logic       take;         // data beat accepted

    assign k2_col   = cols_q - cols_t'(kw2_q) - cols_t'(1);
    assign last_col = cols_q - cols_t'(1);
    assign last_cin = cins_q - cin_t'(1);
    assign cin_last = (cin_cnt == last_cin);
    assign col_last = (col_cnt == last_col);

    assign in_ready = (state == STREAM) & beat.en;           // low while stalled
    assign take     = in_valid & in_ready;

    assign beat.valid = (state == CONFIG) | ((state == STREAM) & in_valid);
    assign beat.lanes = (state == STREAM) ? in_lanes : '0;   // config beat carries zeros
    assign beat.tag   = '{
        is_config:    (state == CONFIG),
        is_cin_last:  (state == STREAM) & cin_last,
        is_cols_1_k2: (state == STREAM) & (col_cnt == k2_col),
        kw2:          kw2_q
    };

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= IDLE;
            kw2_q   <= '0;
            cols_q  <= '0;
            cins_q  <= '0;
            col_cnt <= '0;
            cin_cnt <= '0;
        end else begin
            case (state)
                IDLE: if (start) begin                       // start is a pulse, taken even in a stall
                    kw2_q  <= kw2;
                    cols_q <= cols;
                    cins_q <= cins;
                    state  <= CONFIG;
                end
                CONFIG: if (beat.en) begin                   // config beat leaves
                    col_cnt <= '0;
                    cin_cnt <= '0;
                    state   <= STREAM;
                end
                STREAM: if (take) begin
                    if (cin_last) begin
                        cin_cnt <= '0;
                        col_cnt <= col_cnt + 1'b1;
                        if (col_last) begin                  // frame done
                            col_cnt <= '0;
                            state   <= IDLE;
                        end
                    end else begin
                        cin_cnt <= cin_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_col_in_range: assert property (
        @(posedge aclk) disable iff (rst) (state == STREAM) |-> (col_cnt < cols_q)
    );

endmodule

//--- pad_filter/pad_filter.sv
// horizontal same padding, keep mask, beat valid mask and per-lane edge codes
// luts exist for every odd kernel up to KW_MAX so kw may change per frame
`include "conv_pad_macros.svh"

module pad_filter
    import conv_pad_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,
    conv_stream_if.sink beat,
    output mask_t       keep_mask,
    output logic        valid_mask,
    output clr_t        clr [`MEMBERS-1:0]
);

    localparam int KW2_MAX = `KW_MAX / 2;                   // 7 -> 3
    localparam int MEMBERS = `MEMBERS;

    kw2_t kw2;                                               // selects the lut of this beat
    logic is_config;
    logic is_cin_last;
    logic reg_en;                                            // column boundary or config

    logic [KW2_MAX:1] col_start;                             // one-hot, bit c+1 in start column c
    logic [KW2_MAX:1] col_start_in;
    logic [KW2_MAX:1] col_end_q;                             // bit j set j columns after cols-1-k2
    logic [KW2_MAX:1] col_end_in;

    logic             not_start [KW2_MAX:0];                 // past the first k2 columns
    clr_t             left_lut  [KW2_MAX:0][KW2_MAX:1];      // [kw2][start bit]
    clr_t             clr_left_d;
    clr_t             clr_left;

    assign kw2         = beat.tag.kw2;
    assign is_config   = beat.tag.is_config;
    assign is_cin_last = beat.tag.is_cin_last;
    assign reg_en      = beat.en & beat.valid & (is_cin_last | is_config);

    // shift chains, cleared by the config beat of each frame
    assign col_start_in[1] = is_config & (kw2 != '0);
    assign col_end_in[1]   = !is_config & beat.tag.is_cols_1_k2 & (kw2 != '0);

    for (genvar k = 2; k <= KW2_MAX; k++) begin : g_shift
        assign col_start_in[k] = !is_config & col_start[k-1];
        assign col_end_in[k]   = !is_config & col_end_q[k-1];
    end

    // left codes 1, 3, 5 .. for start columns 0 .. k2-1
    for (genvar g = 0; g <= KW2_MAX; g++) begin : g_left_kw
        for (genvar s = 1; s <= KW2_MAX; s++) begin : g_left_col
            assign left_lut[g][s] = (s <= g) ? clr_t'(2 * s - 1) : '0;
        end
    end

    // registers take next state so they describe the column now arriving
    always_comb begin
        clr_left_d = '0;
        for (int s = 1; s <= KW2_MAX; s++) begin
            if (col_start_in[s]) begin
                clr_left_d = left_lut[kw2][s];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            col_start <= '0;
            col_end_q <= '0;
            clr_left  <= '0;
        end else if (reg_en) begin
            col_start <= col_start_in;
            col_end_q <= col_end_in;
            clr_left  <= clr_left_d;
        end
    end

    assign not_start[0] = 1'b1;                              // kw 1 drops nothing
    for (genvar g = 1; g <= KW2_MAX; g++) begin : g_not_start
        assign not_start[g] = !(|col_start[g:1]);
    end

    for (genvar m = 0; m < MEMBERS; m++) begin : g_lane
        logic [KW2_MAX:0] allow;                             // keep lut, [kw2]
        logic [KW2_MAX:0] next_full;                         // lane just before a full one
        logic [KW2_MAX:1] end_q;                             // masked end register
        logic             end_en;
        clr_t             right;

        assign allow[0]     = 1'b1;
        assign next_full[0] = 1'b1;

        for (genvar g = 1; g <= KW2_MAX; g++) begin : g_kw
            localparam int KW = 2 * g + 1;
            logic full_lane;                                 // m mod kw == kw-1
            logic tail_lane;                                 // partial window allowed in last column

            assign full_lane    = ((m % KW) == KW - 1);
            assign tail_lane    = ((m % KW) >= g) && (m < (MEMBERS / KW) * KW);
            assign next_full[g] = ((m % KW) == KW - 2);
            assign allow[g]     = (not_start[g] & full_lane) | (col_end_q[g] & tail_lane);
        end

        // config clears stale codes left by a previous kernel
        assign end_en = beat.en & beat.valid & (is_config | (is_cin_last & next_full[kw2]));

        always_ff @(posedge aclk) begin
            if (rst) begin
                end_q <= '0;
            end else if (end_en) begin
                end_q <= col_end_in;
            end
        end

        always_comb begin
            right = '0;
            for (int j = 1; j <= KW2_MAX; j++) begin
                if (end_q[j]) begin
                    right = clr_t'(2 * j);                   // 2, 4, 6 towards the right edge
                end
            end
        end

        assign clr[m]       = clr_left | right;
        assign keep_mask[m] = allow[kw2];
    end

    assign valid_mask = not_start[kw2];

    a_start_onehot: assert property (
        @(posedge aclk) disable iff (rst) $onehot0(col_start)
    );

endmodule

//--- tests/conv_pad_tb.sv
// directed testbench for the padding stage, apb setup then framed data streams
// a queue model predicts every output beat, random out_ready exercises stalls
`include "conv_pad_macros.svh"

module conv_pad_tb
    import conv_pad_pkg::*;
();

    localparam int TOTAL_BEATS = 20 + 27 + 24 + 24 + 12;   // data beats of all frames
    localparam int CYCLE_LIMIT = 10 * TOTAL_BEATS + 400;    // stalls and apb traffic on top

    logic               aclk;
    logic               rst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`APB_AW-1:0] paddr;
    logic [`APB_DW-1:0] pwdata;
    logic [`APB_DW-1:0] prdata;
    logic               pready;
    logic               in_valid;
    logic               in_ready;
    lanes_t             in_lanes;
    logic               out_valid;
    logic               out_ready;
    lanes_t             out_lanes;
    mask_t              out_keep;
    clr_t               out_clr [`MEMBERS-1:0];

    int          errors;
    int          cycles = 0;
    int          out_count;          // beats seen leaving the dut
    int          exp_count;          // beats the model predicted
    logic [15:0] data_lfsr;          // lane payload source
    logic [15:0] ready_lfsr;         // out_ready source
    logic        rand_ready;         // back-pressure on
    logic        ready_mode;         // rand_ready as seen at the last rising edge

    lanes_t exp_lanes_q [$];
    mask_t  exp_keep_q  [$];
    bit     exp_last_q  [$];         // beat belongs to the last column
    int     exp_k2_q    [$];

    conv_pad_top dut_i (
        .aclk      (aclk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_lanes  (in_lanes),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_lanes (out_lanes),
        .out_keep  (out_keep),
        .out_clr   (out_clr)
    );

    always #50 aclk = !aclk;

    // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the lsb
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_lanes(output lanes_t v);
        for (int b = 0; b < `MEMBERS * `DATA_W; b++) begin
            data_lfsr = lfsr_next(data_lfsr);                // one step per bit
            v[b / `DATA_W][b % `DATA_W] = data_lfsr[0];
        end
    endtask

    // keep rule per column class, kw = 2 * k2 + 1
    function automatic mask_t model_keep(int k2, bit last_col);
        int    kw;
        mask_t keep;
        kw   = 2 * k2 + 1;
        keep = '0;
        for (int m = 0; m < `MEMBERS; m++) begin
            if (k2 == 0)
                keep[m] = 1'b1;                              // kw 1 keeps everything
            else if (last_col)
                keep[m] = (m % kw >= k2) && (m < (`MEMBERS / kw) * kw);
            else
                keep[m] = (m % kw == kw - 1);                // full windows only
        end
        return keep;
    endfunction

    task automatic compare_lanes(string name, lanes_t got, lanes_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_mask(string name, mask_t got, mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_clr(string name, clr_t got, clr_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_word(string name, logic [`APB_DW-1:0] got, logic [`APB_DW-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // tasks start and end at the drive point, 10 units after a rising edge
    task automatic apb_write(logic [`APB_AW-1:0] addr, logic [`APB_DW-1:0] data);
        psel   = 1'b1;                                       // setup phase
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(posedge aclk);
        #10;
        penable = 1'b1;                                      // access phase
        @(negedge aclk);
        while (!pready) @(negedge aclk);
        @(posedge aclk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(logic [`APB_AW-1:0] addr, output logic [`APB_DW-1:0] data);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(posedge aclk);
        #10;
        penable = 1'b1;
        @(negedge aclk);
        while (!pready) @(negedge aclk);
        data = prdata;                                       // stable mid cycle
        @(posedge aclk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_beat(lanes_t lanes);
        bit accepted;
        in_valid = 1'b1;
        in_lanes = lanes;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge aclk);
            accepted = in_ready;                             // transfer on the coming edge
            @(posedge aclk);
            #10;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_frame(int kw, int cols, int cins);
        int     k2;
        bit     last_col;
        mask_t  keep;
        lanes_t lanes;
        lanes_t exp_l;
        k2 = (kw % 2 == 1 && kw <= `KW_MAX) ? kw / 2 : 0;    // illegal kernel acts as 1
        apb_write('h0, kw);
        apb_write('h4, cols);
        apb_write('h8, cins);
        apb_write('hC, 1);                                   // start
        for (int c = 0; c < cols; c++) begin
            last_col = (c == cols - 1);
            keep     = model_keep(k2, last_col);
            for (int ch = 0; ch < cins; ch++) begin
                random_lanes(lanes);
                if (c >= k2) begin                           // first k2 columns vanish
                    for (int m = 0; m < `MEMBERS; m++) begin
                        exp_l[m] = keep[m] ? lanes[m] : '0;
                    end
                    exp_lanes_q.push_back(exp_l);
                    exp_keep_q.push_back(keep);
                    exp_last_q.push_back(last_col);
                    exp_k2_q.push_back(k2);
                    exp_count++;
                end
                send_beat(lanes);
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_lanes_q.size() != 0) begin                // watchdog catches lost beats
            @(posedge aclk);
            #10;
        end
    endtask

    task automatic check_beat();
        int k2;
        int nonzero;
        bit last_col;
        out_count++;
        if (exp_lanes_q.size() == 0) begin
            errors++;
            $display("output beat %0d arrived while no beat was expected", out_count);
        end else begin
            k2       = exp_k2_q.pop_front();
            last_col = exp_last_q.pop_front();
            compare_lanes("out_lanes", out_lanes, exp_lanes_q.pop_front());
            compare_mask("out_keep", out_keep, exp_keep_q.pop_front());
            nonzero = 0;
            for (int m = 0; m < `MEMBERS; m++) begin
                if (k2 == 0 || !last_col) begin
                    compare_clr($sformatf("out_clr[%0d]", m), out_clr[m], '0);
                end else if (out_clr[m] != '0) begin
                    nonzero++;
                    if (out_clr[m][0]) begin                 // left code at the right edge
                        errors++;
                        $display("CHECK FAILED out_clr[%0d] got 0x%h expected an even code",
                                 m, out_clr[m]);
                    end
                end
            end
            if (k2 != 0 && last_col && nonzero == 0) begin
                errors++;
                $display("last column beat %0d carries no right edge code", out_count);
            end
        end
    endtask

    // sample mid cycle, a beat moves on the next rising edge
    always @(negedge aclk) begin
        if (!rst && out_valid && out_ready) begin
            check_beat();
        end
    end

    always @(posedge aclk) begin
        ready_mode = rand_ready;                             // taken before the drive point
        #10;
        if (ready_mode) begin
            ready_lfsr = lfsr_next(ready_lfsr);
            out_ready  = ready_lfsr[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, expected beats still pending", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic test_apb_config();
        logic [`APB_DW-1:0] rd;
        apb_write('h0, 5);
        apb_read('h0, rd);
        compare_word("kernel width", rd, 5);
        apb_write('h4, 10);
        apb_read('h4, rd);
        compare_word("columns", rd, 10);
        apb_write('h8, 3);
        apb_read('h8, rd);
        compare_word("channels", rd, 3);
        apb_write('h0, 4);                                   // even width
        apb_read('h0, rd);
        compare_word("kernel width", rd, 1);
        apb_write('h0, 9);                                   // above the maximum
        apb_read('h0, rd);
        compare_word("kernel width", rd, 1);
    endtask

    task automatic test_frame_kw3();
        send_frame(3, 10, 2);
        wait_drain();
    endtask

    task automatic test_frames_kw5_kw7();
        send_frame(5, 9, 3);                                 // no drain between frames
        send_frame(7, 12, 2);
        wait_drain();
    endtask

    task automatic test_back_pressure();
        rand_ready = 1'b1;
        send_frame(5, 8, 3);
        wait_drain();
        rand_ready = 1'b0;
    endtask

    task automatic test_kw1();
        send_frame(1, 6, 2);
        wait_drain();
    endtask

    initial begin
        aclk       = 1'b0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        in_valid   = 1'b0;
        in_lanes   = '0;
        out_ready  = 1'b0;
        rand_ready = 1'b0;
        ready_mode = 1'b0;
        data_lfsr  = 16'd21097;
        ready_lfsr = 16'd21097;
        errors     = 0;
        out_count  = 0;
        exp_count  = 0;
        repeat (5) @(posedge aclk);
        #10;
        rst = 1'b0;
        test_apb_config();
        test_frame_kw3();
        test_frames_kw5_kw7();
        test_back_pressure();
        test_kw1();
        compare_word("output beat count", out_count, exp_count);
        $display("errors: %0d, beats checked: %0d", errors, out_count);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
